//--- sim/tb_conv_loop.sv
`include "conv_defines.svh"

module tb_conv_loop import conv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_FRAMES = 6;
	localparam int TOTAL_PIXELS = `MAP_DEPTH * `CH_OUT;
	localparam int FRAME_CYCLES = `MAP_DEPTH * (`CH_OUT + 2) + `CH_OUT * `PASS_GAP + 50;

	logic clk;
	logic reset;
	logic valid_in;
	pixel_t pxl_in;
	logic weight_we;
	wgt_addr_t weight_addr;
	weight_t weight_data;
	pixel_t pxl_out;
	logic pxl_out_valid;
	acc_t result;
	logic result_valid;
	och_t result_och;
	logic frame_done;

	// Reference model of the current frame
	weight_t wgt_m [`CH_OUT * `CH_IN];
	pixel_t pix_m [`MAP_DEPTH];
	acc_t exp_res [`CH_OUT];

	string test_name;
	logic loading;
	int cycle;
	int pix_idx;
	int res_cnt;
	int done_cnt;
	int last_res_cycle;

	conv_loop_top u_dut (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (valid_in),
		.pxl_in       (pxl_in),
		.weight_we    (weight_we),
		.weight_addr  (weight_addr),
		.weight_data  (weight_data),
		.pxl_out      (pxl_out),
		.pxl_out_valid(pxl_out_valid),
		.result       (result),
		.result_valid (result_valid),
		.result_och   (result_och),
		.frame_done   (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: pixel expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_result(input string name, input acc_t exp, input acc_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: result expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_och(input string name, input och_t exp, input och_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: result_och expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: flag expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Model
	////////////////////////////////////////////////////////////////////////////

	// Mode 0 random, 1 all minimum, 2 all maximum, 3 min pixel with max weight
	task automatic fill_frame(input int mode);
		for (int a = 0; a < `CH_OUT * `CH_IN; a++) begin
			case (mode)
				1: wgt_m[a] = weight_t'(8'h80);
				2, 3: wgt_m[a] = weight_t'(8'h7f);
				default: wgt_m[a] = weight_t'($urandom);
			endcase
		end
		for (int p = 0; p < `MAP_DEPTH; p++) begin
			case (mode)
				1, 3: pix_m[p] = pixel_t'(16'h8000);
				2: pix_m[p] = pixel_t'(16'h7fff);
				default: pix_m[p] = pixel_t'($urandom);
			endcase
		end
	endtask

	// Dense layer over the flattened map wrapped to the accumulator width
	task automatic predict_results();
		acc_t sum;
		longint prod;
		for (int o = 0; o < `CH_OUT; o++) begin
			sum = '0;
			for (int p = 0; p < `MAP_DEPTH; p++) begin
				prod = longint'(pix_m[p]) * longint'(wgt_m[o * `CH_IN + p / `IMAGE_SIZE]);
				sum = sum + acc_t'(prod);
			end
			exp_res[o] = sum;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic load_weights();
		for (int a = 0; a < `CH_OUT * `CH_IN; a++) begin
			@(posedge clk);
			#1;
			weight_we = 1'b1;
			weight_addr = wgt_addr_t'(a);
			weight_data = wgt_m[a];
		end
		@(posedge clk);
		#1;
		weight_we = 1'b0;
	endtask

	task automatic send_frame(input bit gapped);
		int i;
		i = 0;
		loading = 1'b1;
		while (i < `MAP_DEPTH) begin
			@(posedge clk);
			#1;
			if (gapped && ($urandom_range(1, 0) == 0)) begin
				valid_in = 1'b0;
			end
			else begin
				valid_in = 1'b1;
				pxl_in = pix_m[i];
				i++;
			end
		end
		@(posedge clk);
		#1;
		valid_in = 1'b0;
		pxl_in = '0;
		loading = 1'b0;
	endtask

	task automatic run_frame(input string name, input int mode, input bit gapped);
		test_name = name;
		fill_frame(mode);
		predict_results();
		pix_idx = 0;
		res_cnt = 0;
		done_cnt = 0;
		last_res_cycle = -10;
		load_weights();
		send_frame(gapped);
		while (done_cnt == 0) begin
			@(posedge clk);
			#1;
		end
		// A few more cycles to catch stray strobes
		repeat (4) @(posedge clk);
		#1;
		if (done_cnt != 1) begin
			$display("%s: frame_done pulsed %0d times", name, done_cnt);
			abort_run();
		end
		if (pix_idx != TOTAL_PIXELS) begin
			$display("%s: replayed %0d pixels, not %0d", name, pix_idx, TOTAL_PIXELS);
			abort_run();
		end
		$display("Frame %s checked", name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			cycle = cycle + 1;
			if (pxl_out_valid) begin
				if (loading) begin
					$display("%s: pxl_out_valid high while a frame is loading", test_name);
					abort_run();
				end
				else if (pix_idx >= TOTAL_PIXELS) begin
					$display("%s: more replayed pixels than the frame holds", test_name);
					abort_run();
				end
				else begin
					check_pixel(test_name, pix_m[pix_idx % `MAP_DEPTH], pxl_out);
					pix_idx++;
				end
			end
			if (result_valid) begin
				if (res_cnt >= `CH_OUT) begin
					$display("%s: more results than output channels", test_name);
					abort_run();
				end
				else begin
					check_och(test_name, och_t'(res_cnt), result_och);
					check_result(test_name, exp_res[res_cnt], result);
					res_cnt++;
					last_res_cycle = cycle;
				end
			end
			if (frame_done) begin
				if (res_cnt != `CH_OUT || last_res_cycle != cycle - 1) begin
					$display("%s: frame_done not one cycle after the last result", test_name);
					abort_run();
				end
				done_cnt++;
			end
		end
	end

	initial begin
		repeat (NUM_FRAMES * FRAME_CYCLES) @(posedge clk);
		$display("Run timed out waiting for results");
		abort_run();
	end

	initial begin
		void'($urandom(32'h7046));
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		weight_we = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		loading = 1'b0;
		test_name = "reset";
		cycle = 0;
		pix_idx = 0;
		res_cnt = 0;
		done_cnt = 0;
		last_res_cycle = -10;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag("reset pxl_out_valid", 1'b0, pxl_out_valid);
		check_flag("reset result_valid", 1'b0, result_valid);
		check_flag("reset frame_done", 1'b0, frame_done);

		run_frame("random", 0, 1'b0);
		run_frame("back_to_back", 0, 1'b0);
		run_frame("gapped", 0, 1'b1);
		run_frame("all_min", 1, 1'b0);
		run_frame("all_max", 2, 1'b0);
		run_frame("min_pixel_max_weight", 3, 1'b0);

		$display("** PASS **");
		$finish;
	end

endmodule

//--- source/channel_mac.sv
`include "conv_defines.svh"

module channel_mac import conv_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      weight_we,
	input  wgt_addr_t weight_addr,
	input  weight_t   weight_data,
	input  pixel_t    pxl,
	input  logic      pxl_valid,
	input  och_t      och,
	input  ich_t      ich,
	input  logic      pass_last,
	output acc_t      result,
	output logic      result_valid,
	output och_t      result_och
);

	wgt_addr_t wgt_rd_addr;
	wgt_addr_t wgt_addr;
	logic [`WEIGHT_WIDTH-1:0] wgt_dout;
	weight_t wgt;

	// Pixel side delayed to meet the weight
	pixel_t pxl_d;
	logic valid_d;
	logic last_d;
	logic first_d;
	och_t och_d;
	logic in_pass;

	logic signed [`DATA_WIDTH+`WEIGHT_WIDTH-1:0] product;
	acc_t product_ext;
	acc_t acc;

	////////////////////////////////////////////////////////////////////////////
	// Weight store
	////////////////////////////////////////////////////////////////////////////

	assign wgt_rd_addr = wgt_addr_t'(och * `CH_IN + ich);
	assign wgt_addr = weight_we ? weight_addr : wgt_rd_addr;
	assign wgt = wgt_dout;

	fmap_ram #(
		.WIDTH(`WEIGHT_WIDTH),
		.DEPTH(`CH_OUT * `CH_IN)
	) u_weight_ram (
		.clk (clk),
		.we  (weight_we),
		.addr(wgt_addr),
		.din (weight_data),
		.dout(wgt_dout)
	);

	////////////////////////////////////////////////////////////////////////////
	// Multiply accumulate
	////////////////////////////////////////////////////////////////////////////

	assign product = pxl_d * wgt;
	assign product_ext = acc_t'(product);
	assign result = acc;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_d <= 1'b0;
			last_d <= 1'b0;
			first_d <= 1'b0;
			in_pass <= 1'b0;
			result_valid <= 1'b0;
		end
		else begin
			valid_d <= pxl_valid;
			last_d <= pxl_valid && pass_last;
			first_d <= pxl_valid && !in_pass;
			if (pxl_valid) begin
				in_pass <= !pass_last;
			end
			result_valid <= valid_d && last_d;
		end
	end

	// Sum wraps at ACC_WIDTH
	always_ff @(posedge clk) begin
		pxl_d <= pxl;
		och_d <= och;
		if (valid_d) begin
			acc <= first_d ? product_ext : acc + product_ext;
		end
		if (valid_d && last_d) begin
			result_och <= och_d;
		end
	end

endmodule

//--- source/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Map geometry
////////////////////////////////////////////////////////////////////////////

// Side of the square map
`define IMAGE_WIDTH 4
`define IMAGE_SIZE (`IMAGE_WIDTH * `IMAGE_WIDTH)

`define CH_IN 4
`define CH_OUT 3

// Pixels held for one full frame
`define MAP_DEPTH (`CH_IN * `IMAGE_SIZE)

// Idle cycles between two replay passes
`define PASS_GAP 5

////////////////////////////////////////////////////////////////////////////
// Data widths
////////////////////////////////////////////////////////////////////////////

`define DATA_WIDTH 16
`define WEIGHT_WIDTH 8
`define ACC_WIDTH 32

`endif

//--- source/conv_loop_top.sv
module conv_loop_top import conv_pkg::*; (
	input  logic      clk,
	input  logic      reset,

	// Frame input
	input  logic      valid_in,
	input  pixel_t    pxl_in,

	// Weight write port
	input  logic      weight_we,
	input  wgt_addr_t weight_addr,
	input  weight_t   weight_data,

	// Replayed map
	output pixel_t    pxl_out,
	output logic      pxl_out_valid,

	// One result per output channel
	output acc_t      result,
	output logic      result_valid,
	output och_t      result_och,
	output logic      frame_done
);

	och_t och;
	ich_t ich;
	logic pass_last;

	////////////////////////////////////////////////////////////////////////////
	// Frame store and replay
	////////////////////////////////////////////////////////////////////////////

	fmap_loop_buffer u_loop_buffer (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.pxl       (pxl_out),
		.pxl_valid (pxl_out_valid),
		.och       (och),
		.ich       (ich),
		.pass_last (pass_last),
		.frame_done(frame_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Dot product per output channel
	////////////////////////////////////////////////////////////////////////////

	channel_mac u_channel_mac (
		.clk         (clk),
		.reset       (reset),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.pxl         (pxl_out),
		.pxl_valid   (pxl_out_valid),
		.och         (och),
		.ich         (ich),
		.pass_last   (pass_last),
		.result      (result),
		.result_valid(result_valid),
		.result_och  (result_och)
	);

endmodule

//--- source/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

	// Index widths where a single channel still needs one bit
	localparam int MAP_ADDR_W = $clog2(`MAP_DEPTH);
	localparam int WGT_ADDR_W = $clog2(`CH_OUT * `CH_IN);
	localparam int OCH_W = (`CH_OUT > 1) ? $clog2(`CH_OUT) : 1;
	localparam int ICH_W = (`CH_IN > 1) ? $clog2(`CH_IN) : 1;

	typedef logic signed [`DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	typedef logic [MAP_ADDR_W-1:0] map_addr_t;
	typedef logic [WGT_ADDR_W-1:0] wgt_addr_t;
	typedef logic [OCH_W-1:0] och_t;
	typedef logic [ICH_W-1:0] ich_t;

	// Loop buffer sequence
	typedef enum logic [1:0] {
		ST_LOAD,
		ST_REPLAY,
		ST_GAP,
		ST_DONE
	} replay_state_t;

endpackage

//--- source/fmap_loop_buffer.sv
`include "conv_defines.svh"

module fmap_loop_buffer import conv_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   valid_in,
	input  pixel_t pxl_in,
	output pixel_t pxl,
	output logic   pxl_valid,
	output och_t   och,
	output ich_t   ich,
	output logic   pass_last,
	output logic   frame_done
);

	// Cycles in done before the pulse
	// 2 for RAM read and output register, 2 more in the MAC
	localparam int DONE_CYCLES = 4;
	localparam int WAIT_MAX = (`PASS_GAP > DONE_CYCLES) ? `PASS_GAP : DONE_CYCLES;
	localparam int WAIT_W = $clog2(WAIT_MAX + 1);

	replay_state_t state;
	map_addr_t addr_cnt;
	och_t pass_cnt;
	logic [WAIT_W-1:0] wait_cnt;

	logic ram_we;
	logic rd_issue;
	logic addr_end;
	logic [`DATA_WIDTH-1:0] ram_dout;

	// Control aligned with RAM read data
	logic rd_valid_q;
	logic rd_last_q;
	och_t och_q;
	ich_t ich_q;

	assign ram_we = (state == ST_LOAD) && valid_in;
	assign rd_issue = (state == ST_REPLAY);
	assign addr_end = (addr_cnt == map_addr_t'(`MAP_DEPTH - 1));

	////////////////////////////////////////////////////////////////////////////
	// Frame store
	////////////////////////////////////////////////////////////////////////////

	fmap_ram #(
		.WIDTH(`DATA_WIDTH),
		.DEPTH(`MAP_DEPTH)
	) u_pixel_ram (
		.clk (clk),
		.we  (ram_we),
		.addr(addr_cnt),
		.din (pxl_in),
		.dout(ram_dout)
	);

	////////////////////////////////////////////////////////////////////////////
	// Load / replay FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_LOAD;
			addr_cnt <= '0;
			pass_cnt <= '0;
			wait_cnt <= '0;
			frame_done <= 1'b0;
		end
		else begin
			frame_done <= 1'b0;
			case (state)
				ST_LOAD: begin
					if (valid_in) begin
						if (addr_end) begin
							addr_cnt <= '0;
							state <= ST_REPLAY;
						end
						else begin
							addr_cnt <= addr_cnt + 1'b1;
						end
					end
				end
				ST_REPLAY: begin
					if (addr_end) begin
						addr_cnt <= '0;
						wait_cnt <= '0;
						if (pass_cnt == och_t'(`CH_OUT - 1)) begin
							state <= ST_DONE;
						end
						else begin
							pass_cnt <= pass_cnt + 1'b1;
							state <= ST_GAP;
						end
					end
					else begin
						addr_cnt <= addr_cnt + 1'b1;
					end
				end
				ST_GAP: begin
					if (wait_cnt == WAIT_W'(`PASS_GAP - 1)) begin
						state <= ST_REPLAY;
					end
					else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_DONE: begin
					// Last result is out and the next frame may load
					if (wait_cnt == WAIT_W'(DONE_CYCLES - 1)) begin
						frame_done <= 1'b1;
						pass_cnt <= '0;
						state <= ST_LOAD;
					end
					else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Replay pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
			rd_last_q <= 1'b0;
			pxl_valid <= 1'b0;
			pass_last <= 1'b0;
		end
		else begin
			rd_valid_q <= rd_issue;
			rd_last_q <= rd_issue && addr_end;
			pxl_valid <= rd_valid_q;
			pass_last <= rd_last_q;
		end
	end

	// Channel tags travel beside the pixel
	always_ff @(posedge clk) begin
		och_q <= pass_cnt;
		ich_q <= ich_t'(addr_cnt / `IMAGE_SIZE);
		pxl <= ram_dout;
		och <= och_q;
		ich <= ich_q;
	end

endmodule

//--- source/fmap_ram.sv
module fmap_ram #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 64
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         din,
	output logic [WIDTH-1:0]         dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Single port, write first, one cycle read latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= din;
			// New data shows on the read port
			dout <= din;
		end
		else begin
			dout <= mem[addr];
		end
	end

endmodule

//--- verilog.f
+incdir+source
source/conv_pkg.sv
source/fmap_ram.sv
source/fmap_loop_buffer.sv
source/channel_mac.sv
source/conv_loop_top.sv
sim/tb_conv_loop.sv
